/* rtl/front_panel_pkg.sv */
`default_nettype none

package front_panel_pkg;

	// Display geometry
	localparam int readout_n = 4;                       // Readout modules
	localparam int readout_w = 4;                       // Digits per module
	localparam int readout_n_bits = $clog2(readout_n);
	localparam int readout_w_bits = $clog2(readout_w);
	localparam int digit_n = readout_n * readout_w;
	localparam int digit_idx_w = readout_n_bits + readout_w_bits;

	// Values and conversion
	localparam int val_w = 10;
	localparam logic [val_w-1:0] val_max = 10'd999;     // Largest shown value
	localparam int bcd_n = 3;
	localparam int conv_clocks = 10;                    // One step per input bit
	localparam int conv_cnt_w = $clog2(conv_clocks + 1);

	localparam int seg_w = 8;                           // a..g plus dp
	localparam int pwm_w = 9;

	// Timing, 50 clocks per ms
	localparam int scan_clocks = 8;
	localparam int scan_cnt_w = $clog2(scan_clocks);
	localparam int wrn_on_clocks = 10000;
	localparam int wrn_off_clocks = 15000;
	localparam int readout_on_clocks = 600;
	localparam int readout_off_clocks = 900;

	typedef enum logic [1:0] {boost, afr, oil, coolant} gauge_sel_t;

	// Active high, bit 0 is segment a
	localparam logic [seg_w-1:0] seg_font [10] = '{
		8'h3f, 8'h06, 8'h5b, 8'h4f, 8'h66,
		8'h6d, 8'h7d, 8'h07, 8'h7f, 8'h6f
	};
	localparam logic [seg_w-1:0] seg_minus = 8'h40;     // Segment g only
	localparam logic [seg_w-1:0] seg_blank = 8'h00;

endpackage

`default_nettype wire

/* rtl/blinker.sv */
`default_nettype none

module blinker
#(
	parameter int on_clocks = 2,
	parameter int off_clocks = 2
)
(
	input logic clk,
	input logic reset,
	input logic blink,
	output logic out
);

	// Position inside one on/off period
	logic [$clog2(on_clocks + off_clocks)-1:0] cnt_reg;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			cnt_reg <= '0;
			out <= 1'b0;
		end
		else if (!blink)
		begin
			// Restart from the on phase
			cnt_reg <= '0;
			out <= 1'b0;
		end
		else
		begin
			out <= (cnt_reg < on_clocks);   // First part of period lit
			if (cnt_reg == on_clocks + off_clocks - 1)
				cnt_reg <= '0;
			else
				cnt_reg <= cnt_reg + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* rtl/brightness_pwm.sv */
`default_nettype none

module brightness_pwm
	import front_panel_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic disp_en,
	input logic [pwm_w-1:0] disp_w,
	output logic en
);

	logic [pwm_w-1:0] cnt_reg;

	// Free running, wraps every 512 clocks
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			cnt_reg <= '0;
		else
			cnt_reg <= cnt_reg + 1'b1;
	end

	// Duty cycle is disp_w out of 512
	assign en = disp_en && (cnt_reg < disp_w);

endmodule

`default_nettype wire

/* rtl/readout_sequencer.sv */
`default_nettype none

module readout_sequencer
	import front_panel_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [val_w-1:0] boost_val,
	input logic [val_w-1:0] afr_val,
	input logic [val_w-1:0] oil_val,
	input logic [val_w-1:0] coolant_val,
	input logic boost_sign,
	input logic boost_wrn,
	input logic afr_wrn,
	input logic done_tick,
	output logic wr,
	output gauge_sel_t sel,
	output logic [val_w-1:0] val,
	output logic mantissa,
	output logic sign,
	output logic blink
);

	typedef enum logic {s_start, s_wait} state_t;

	state_t state_reg, state_next;
	gauge_sel_t sel_next;
	logic load;                         // Issue a write this edge
	logic [val_w-1:0] val_next;
	logic mantissa_next, sign_next, blink_next;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state_reg <= s_start;
			sel <= boost;
			wr <= 1'b0;
		end
		else
		begin
			state_reg <= state_next;
			sel <= sel_next;
			wr <= load;                 // One cycle strobe
		end
	end

	// Write payload, held until the next write
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			val <= val_next;
			mantissa <= mantissa_next;
			sign <= sign_next;
			blink <= blink_next;
		end
	end

	// Issue/wait control
	always_comb
	begin
		state_next = state_reg;
		sel_next = sel;
		load = 1'b0;
		case (state_reg)
			s_start:
			begin
				sel_next = boost;
				load = 1'b1;
				state_next = s_wait;
			end
			default:
				if (done_tick)          // Store has committed, move on
				begin
					sel_next = gauge_sel_t'(sel + 2'd1);
					load = 1'b1;
				end
		endcase
	end

	// Per gauge format
	always_comb
	begin
		case (sel_next)
			boost:
			begin
				val_next = boost_val;
				mantissa_next = 1'b1;
				sign_next = boost_sign;
				blink_next = boost_wrn;
			end
			afr:
			begin
				val_next = afr_val;
				mantissa_next = 1'b1;
				sign_next = 1'b0;
				blink_next = afr_wrn;
			end
			oil:
			begin
				val_next = oil_val;
				mantissa_next = 1'b0;
				sign_next = 1'b0;
				blink_next = 1'b0;
			end
			default:
			begin
				val_next = coolant_val;
				mantissa_next = 1'b0;
				sign_next = 1'b0;
				blink_next = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* rtl/readout_store.sv */
`default_nettype none

module readout_store
	import front_panel_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic wr,
	input logic mantissa,
	input logic sign,
	input logic blink,
	input gauge_sel_t sel,
	input logic [val_w-1:0] val,
	output logic done_tick,
	output logic [readout_n-1:0][bcd_n-1:0][3:0] digit_bcd,
	output logic [readout_n-1:0] dp_flags,
	output logic [readout_n-1:0] sign_flags,
	output logic [readout_n-1:0] blink_flags
);

	logic busy;
	logic [conv_cnt_w-1:0] cnt_reg;     // Steps left
	logic [val_w-1:0] bin_reg;
	logic [bcd_n*4-1:0] bcd_reg, bcd_adj, bcd_step;
	gauge_sel_t sel_reg;
	logic dp_reg, sign_reg, blink_reg;

	// Shift-and-add step
	always_comb
	begin
		for (int i = 0; i < bcd_n; i++)
			bcd_adj[i*4 +: 4] = (bcd_reg[i*4 +: 4] > 4'd4) ?
				bcd_reg[i*4 +: 4] + 4'd3 : bcd_reg[i*4 +: 4];
		bcd_step = {bcd_adj[bcd_n*4-2:0], bin_reg[val_w-1]};
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			cnt_reg <= '0;
			done_tick <= 1'b0;
			digit_bcd <= '0;
			dp_flags <= '0;
			sign_flags <= '0;
			blink_flags <= '0;
		end
		else
		begin
			done_tick <= 1'b0;
			if (wr)
			begin
				busy <= 1'b1;
				cnt_reg <= conv_cnt_w'(conv_clocks);
			end
			else if (busy)
			begin
				cnt_reg <= cnt_reg - 1'b1;
				if (cnt_reg == 1)       // Last step, commit the entry
				begin
					busy <= 1'b0;
					done_tick <= 1'b1;
					digit_bcd[sel_reg] <= bcd_step;
					dp_flags[sel_reg] <= dp_reg;
					sign_flags[sel_reg] <= sign_reg;
					blink_flags[sel_reg] <= blink_reg;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr)
		begin
			bin_reg <= (val > val_max) ? val_max : val;   // Clamp
			bcd_reg <= '0;
			sel_reg <= sel;
			dp_reg <= mantissa;
			sign_reg <= sign;
			blink_reg <= blink;
		end
		else if (busy)
		begin
			bin_reg <= {bin_reg[val_w-2:0], 1'b0};
			bcd_reg <= bcd_step;
		end
	end

endmodule

`default_nettype wire

/* rtl/readout_scanner.sv */
`default_nettype none

module readout_scanner
	import front_panel_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic en,
	input logic [readout_n-1:0][bcd_n-1:0][3:0] digit_bcd,
	input logic [readout_n-1:0] dp_flags,
	input logic [readout_n-1:0] sign_flags,
	input logic [readout_n-1:0] blink_flags,
	output logic [seg_w-1:0] sseg,
	output logic [digit_n-1:0] c
);

	logic [scan_cnt_w-1:0] tick_reg;    // Clocks on current digit
	logic [digit_idx_w-1:0] idx_reg;    // Current digit
	logic [readout_n_bits-1:0] mod_i;
	logic [readout_w_bits-1:0] pos_i;
	logic [seg_w-1:0] seg_pat;
	logic readout_on;
	logic any_blink;

	// Shared blink phase for all modules
	assign any_blink = |blink_flags;

	blinker
	#(
		.on_clocks(readout_on_clocks),
		.off_clocks(readout_off_clocks)
	)
	readout_blink
	(
		.clk(clk),
		.reset(reset),
		.blink(any_blink),
		.out(readout_on)
	);

	// Digit k is module k/4, position k mod 4
	assign mod_i = idx_reg[digit_idx_w-1:readout_w_bits];
	assign pos_i = idx_reg[readout_w_bits-1:0];

	always_comb
	begin
		case (pos_i)
			0:
				seg_pat = sign_flags[mod_i] ? seg_minus : seg_blank;
			1:
				seg_pat = seg_font[digit_bcd[mod_i][2]];    // Hundreds
			2:
				// Tens, with the decimal point after it
				seg_pat = seg_font[digit_bcd[mod_i][1]] |
					{dp_flags[mod_i], {(seg_w-1){1'b0}}};
			default:
				seg_pat = seg_font[digit_bcd[mod_i][0]];    // Units
		endcase
		if (blink_flags[mod_i] && !readout_on)
			seg_pat = seg_blank;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			tick_reg <= '0;
			idx_reg <= '0;
			sseg <= '0;
			c <= '0;
		end
		else
		begin
			if (tick_reg == scan_clocks - 1)
			begin
				tick_reg <= '0;
				idx_reg <= idx_reg + 1'b1;  // Wraps after the last digit
			end
			else
			begin
				tick_reg <= tick_reg + 1'b1;
			end

			sseg <= seg_pat;
			// One-hot enable, dark while PWM is off
			if (en)
				c <= {{(digit_n-1){1'b0}}, 1'b1} << idx_reg;
			else
				c <= '0;
		end
	end

endmodule

`default_nettype wire

/* rtl/front_panel_controller.sv */
`default_nettype none

module front_panel_controller
	import front_panel_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [pwm_w-1:0] disp_w,         // Brightness
	input logic disp_en,
	input logic [val_w-1:0] boost_val,
	input logic [val_w-1:0] afr_val,
	input logic [val_w-1:0] oil_val,
	input logic [val_w-1:0] coolant_val,
	input logic boost_sign,                 // Boost is negative
	input logic wrn,
	input logic boost_wrn,
	input logic afr_wrn,
	output logic [seg_w-1:0] sseg,
	output logic [digit_n-1:0] c,
	output logic warning
);

	logic en;

	// Sequencer to store
	logic wr, mantissa, sign, blink, done_tick;
	gauge_sel_t sel;
	logic [val_w-1:0] val;

	// Store to scanner
	logic [readout_n-1:0][bcd_n-1:0][3:0] digit_bcd;
	logic [readout_n-1:0] dp_flags, sign_flags, blink_flags;

	brightness_pwm brightness_pwm
	(
		.clk(clk), .reset(reset),
		.disp_en(disp_en), .disp_w(disp_w), .en(en)
	);

	blinker
	#(
		.on_clocks(wrn_on_clocks),
		.off_clocks(wrn_off_clocks)
	)
	warning_blinker
	(
		.clk(clk), .reset(reset), .blink(wrn), .out(warning)
	);

	readout_sequencer readout_sequencer
	(
		.clk(clk), .reset(reset),
		.boost_val(boost_val), .afr_val(afr_val),
		.oil_val(oil_val), .coolant_val(coolant_val),
		.boost_sign(boost_sign), .boost_wrn(boost_wrn), .afr_wrn(afr_wrn),
		.done_tick(done_tick), .wr(wr), .sel(sel), .val(val),
		.mantissa(mantissa), .sign(sign), .blink(blink)
	);

	readout_store readout_store
	(
		.clk(clk), .reset(reset),
		.wr(wr), .mantissa(mantissa), .sign(sign), .blink(blink),
		.sel(sel), .val(val), .done_tick(done_tick),
		.digit_bcd(digit_bcd), .dp_flags(dp_flags),
		.sign_flags(sign_flags), .blink_flags(blink_flags)
	);

	readout_scanner readout_scanner
	(
		.clk(clk), .reset(reset), .en(en),
		.digit_bcd(digit_bcd), .dp_flags(dp_flags),
		.sign_flags(sign_flags), .blink_flags(blink_flags),
		.sseg(sseg), .c(c)
	);

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
`default_nettype none

module tb_clock
#(
	parameter int half_period = 5
)
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
			#half_period clk = ~clk;    // Period of 10
	end

endmodule

`default_nettype wire

/* testbench/front_panel_tb.sv */
`default_nettype none

module front_panel_tb
	import front_panel_pkg::*;
();

	localparam int timeout_cycles = 120000;    // Well above all tests together

	logic clk;
	logic reset;
	logic [pwm_w-1:0] disp_w;
	logic disp_en;
	logic [val_w-1:0] boost_val, afr_val, oil_val, coolant_val;
	logic boost_sign, wrn, boost_wrn, afr_wrn;
	logic [seg_w-1:0] sseg;
	logic [digit_n-1:0] c;
	logic warning;

	int cycles = 0;
	int shown_val [readout_n];     // Last value driven per module
	logic shown_sign [readout_n];

	tb_clock clock_gen (.clk(clk));

	front_panel_controller uut
	(
		.clk(clk), .reset(reset), .disp_w(disp_w), .disp_en(disp_en),
		.boost_val(boost_val), .afr_val(afr_val),
		.oil_val(oil_val), .coolant_val(coolant_val),
		.boost_sign(boost_sign), .wrn(wrn), .boost_wrn(boost_wrn), .afr_wrn(afr_wrn),
		.sseg(sseg), .c(c), .warning(warning)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_seg(input string test, input int digit,
		input logic [seg_w-1:0] expected, input logic [seg_w-1:0] actual);
		if (actual !== expected)
			abort_run($sformatf("FAIL %s digit %0d expected %h actual %h",
				test, digit, expected, actual));
	endtask

	task automatic check_count(input string test, input int expected, input int actual);
		if (actual != expected)
			abort_run($sformatf("FAIL %s expected %0d actual %0d", test, expected, actual));
	endtask

	// Expected pattern of digit k with values clamped to 999
	function automatic logic [seg_w-1:0] expected_seg(input int k);
		int m;
		int v;
		logic [seg_w-1:0] pat;
		logic [seg_w-1:0] point;
		m = k / readout_w;
		v = (shown_val[m] > int'(val_max)) ? int'(val_max) : shown_val[m];
		point = '0;
		if (m == int'(boost) || m == int'(afr))
			point[seg_w-1] = 1'b1;
		case (k % readout_w)
			0: pat = shown_sign[m] ? seg_minus : seg_blank;
			1: pat = seg_font[v / 100];
			2: pat = seg_font[(v / 10) % 10] | point;
			default: pat = seg_font[v % 10];
		endcase
		return pat;
	endfunction

	function automatic int active_digit(input logic [digit_n-1:0] cv);
		int k;
		k = -1;
		for (int i = 0; i < digit_n; i++)
			if (cv[i])
				k = i;
		return k;
	endfunction

	task automatic set_gauges(input int b, input int a, input int o, input int cl,
		input logic bs);
		@(posedge clk);
		boost_val <= val_w'(b);
		afr_val <= val_w'(a);
		oil_val <= val_w'(o);
		coolant_val <= val_w'(cl);
		boost_sign <= bs;
		shown_val[int'(boost)] = b;
		shown_val[int'(afr)] = a;
		shown_val[int'(oil)] = o;
		shown_val[int'(coolant)] = cl;
		for (int m = 0; m < readout_n; m++)
			shown_sign[m] = (m == int'(boost)) ? bs : 1'b0;
	endtask

	// Wait for each digit enable in turn and check its segments
	task automatic scan_digits(input string test, input int first, input int last);
		logic [digit_n-1:0] want;
		for (int k = first; k <= last; k++)
		begin
			want = '0;
			want[k] = 1'b1;
			@(negedge clk);
			while (c != want)
				@(negedge clk);
			check_seg(test, k, expected_seg(k), sseg);
		end
	endtask

	task automatic idle_after_reset();
		int lit_n;
		int lamp_n;
		lit_n = 0;
		lamp_n = 0;
		repeat (200)
		begin
			@(negedge clk);
			if (c != '0)
				lit_n++;
			if (warning)
				lamp_n++;
		end
		check_count("reset state digits", 0, lit_n);
		check_count("reset state warning", 0, lamp_n);
	endtask

	task automatic show_readouts();
		set_gauges(123, 147, 85, 210, 1'b1);
		disp_w <= pwm_w'(511);
		disp_en <= 1'b1;
		repeat (300) @(posedge clk);      // Several sequencer rounds
		scan_digits("readout contents", 0, digit_n - 1);
	endtask

	task automatic clamp_oil();
		set_gauges(123, 147, 1000, 210, 1'b1);
		repeat (300) @(posedge clk);
		scan_digits("clamping", int'(oil) * readout_w, int'(oil) * readout_w + readout_w - 1);
	endtask

	task automatic dim_display();
		int n;
		n = 0;
		@(posedge clk);
		disp_w <= pwm_w'(100);
		repeat (2) @(posedge clk);        // c follows en by one clock
		repeat (1024)
		begin
			@(negedge clk);
			if (c != '0)
				n++;
		end
		check_count("brightness", 200, n);
	endtask

	task automatic flash_warning();
		int n;
		@(posedge clk);
		wrn <= 1'b1;
		n = 0;
		@(negedge clk);
		while (!warning)
		begin
			n++;
			@(negedge clk);
		end
		check_count("warning rise", 1, n);
		n = 0;
		while (warning)
		begin
			n++;
			@(negedge clk);
		end
		check_count("warning on time", wrn_on_clocks, n);
		n = 0;
		while (!warning)
		begin
			n++;
			@(negedge clk);
		end
		check_count("warning off time", wrn_off_clocks, n);
		// Lamp is lit again so drop the request
		@(posedge clk);
		wrn <= 1'b0;
		n = 0;
		@(negedge clk);
		while (warning)
		begin
			n++;
			@(negedge clk);
		end
		check_count("warning drop", 1, n);
	endtask

	task automatic blink_boost();
		int k;
		int blank_n;
		int lit_n;
		blank_n = 0;
		lit_n = 0;
		@(posedge clk);
		disp_w <= pwm_w'(511);
		boost_wrn <= 1'b1;
		repeat (100) @(posedge clk);      // Flag is in the store after one round
		repeat (1500)
		begin
			@(negedge clk);
			k = active_digit(c);
			if (k >= int'(boost) * readout_w && k < (int'(boost) + 1) * readout_w)
			begin
				if (sseg == seg_blank)
					blank_n++;
				else
				begin
					lit_n++;
					check_seg("readout blink", k, expected_seg(k), sseg);
				end
			end
			else if (k >= int'(oil) * readout_w && k < (int'(oil) + 1) * readout_w)
				check_seg("readout blink", k, expected_seg(k), sseg);
		end
		if (blank_n == 0)
			abort_run("boost digits were never blanked while boost_wrn was set");
		else if (lit_n == 0)
			abort_run("boost digits were never lit while boost_wrn was set");
	endtask

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles == timeout_cycles)
			abort_run($sformatf("timeout, tests still running after %0d cycles", cycles));
	end

	initial
	begin
		reset = 1'b1;
		disp_w = '0;
		disp_en = 1'b0;
		boost_val = '0;
		afr_val = '0;
		oil_val = '0;
		coolant_val = '0;
		boost_sign = 1'b0;
		wrn = 1'b0;
		boost_wrn = 1'b0;
		afr_wrn = 1'b0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		idle_after_reset();
		show_readouts();
		clamp_oil();
		dim_display();
		flash_warning();
		blink_boost();
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* front_panel.f */
rtl/front_panel_pkg.sv
rtl/blinker.sv
rtl/brightness_pwm.sv
rtl/readout_sequencer.sv
rtl/readout_store.sv
rtl/readout_scanner.sv
rtl/front_panel_controller.sv
testbench/tb_clock.sv
testbench/front_panel_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the front panel testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module front_panel_tb \
	-f front_panel.f -Mdir obj_dir || exit 1
out=$(./obj_dir/Vfront_panel_tb)
echo "$out"
echo "$out" | grep -qF '>>> PASS' && echo "run_sim: passed" || { echo "run_sim: failed"; exit 1; }
